// File: verilog/retire_config.svh
`ifndef RETIRE_CONFIG_SVH
`define RETIRE_CONFIG_SVH

// Number of instructions that can retire in one cycle.
`define ISSUE_NUM 2

// The trace queue holds 2**QUEUE_DEPTH_LOG2 register writes.
`define QUEUE_DEPTH_LOG2 6

// Configuration register map.
// Bit 0 of CTRL enables tracing, bit 1 filters writes to register zero.
`define CFG_ADDR_CTRL 2'd0
// Reads the number of lost writes; any write clears it.
`define CFG_ADDR_DROPS 2'd1
// Reads the current queue occupancy.
`define CFG_ADDR_LEVEL 2'd2

`endif

// File: verilog/retire_pkg.sv
`default_nettype none

`include "retire_config.svh"

package retire_pkg;

    // One data word or program counter.
    typedef logic [31:0] word_t;

    // Architectural register number.
    typedef logic [4:0] reg_addr_t;

    // Occupied queue entries, one bit wider than the pointers so a full queue fits.
    typedef logic [`QUEUE_DEPTH_LOG2:0] slot_count_t;

    // Saturating count of writes lost to a full queue.
    typedef logic [15:0] drop_count_t;

endpackage

`default_nettype wire

// File: verilog/retire_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

// Two retire slots after filtering.
// Slot 1 always holds the older write; slot 0 is only valid alongside slot 1.
interface retire_if
    import retire_pkg::*;
    ();

    logic [`ISSUE_NUM-1:0] wen;     // One-cycle strobe per slot.
    reg_addr_t [`ISSUE_NUM-1:0] addr;
    word_t [`ISSUE_NUM-1:0] data;
    word_t [`ISSUE_NUM-1:0] pc;

    modport source
    (
        output wen,
        output addr,
        output data,
        output pc
    );

    modport sink
    (
        input wen,
        input addr,
        input data,
        input pc
    );

endinterface

`default_nettype wire

// File: verilog/trace_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module trace_config_regs
    import retire_pkg::*;
    (
        input wire logic clk,
        input wire logic reset,
        input wire logic cfg_we,
        input wire logic [1:0] cfg_addr,
        input wire word_t cfg_wdata,
        output word_t cfg_rdata,
        input wire logic drop_strobe,
        input wire logic [1:0] drop_amount,
        input wire slot_count_t level,
        output logic trace_enable,
        output logic drop_zero
    );

    drop_count_t drop_count;
    logic [$bits(drop_count_t):0] drop_sum;   // One extra bit catches overflow.

    assign drop_sum = {1'b0, drop_count} + ($bits(drop_count_t) + 1)'(drop_amount);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            trace_enable <= 1'b1;               // Tracing is on out of reset.
            drop_zero <= 1'b0;
        end
        else if (cfg_we && cfg_addr == `CFG_ADDR_CTRL)
        begin
            trace_enable <= cfg_wdata[0];
            drop_zero <= cfg_wdata[1];
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            drop_count <= '0;
        end
        else if (cfg_we && cfg_addr == `CFG_ADDR_DROPS)
        begin
            // A clear that meets a drop keeps the new loss.
            drop_count <= drop_strobe ? drop_count_t'(drop_amount) : '0;
        end
        else if (drop_strobe)
        begin
            if (drop_sum[$bits(drop_count_t)])
                drop_count <= '1;               // Saturate rather than wrap.
            else
                drop_count <= drop_sum[$bits(drop_count_t)-1:0];
        end
    end

    always_comb
    begin
        case (cfg_addr)
            `CFG_ADDR_CTRL:  cfg_rdata = {30'b0, drop_zero, trace_enable};
            `CFG_ADDR_DROPS: cfg_rdata = word_t'(drop_count);
            `CFG_ADDR_LEVEL: cfg_rdata = word_t'(level);
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/retire_compactor.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module retire_compactor
    import retire_pkg::*;
    (
        input wire logic clk,
        input wire logic reset,
        input wire logic [`ISSUE_NUM-1:0] rf_wen,
        input wire reg_addr_t [`ISSUE_NUM-1:0] rf_addr,
        input wire word_t [`ISSUE_NUM-1:0] rf_data,
        input wire word_t [`ISSUE_NUM-1:0] rt_pc,
        input wire logic trace_enable,
        input wire logic drop_zero,
        retire_if.source slots
    );

    logic [`ISSUE_NUM-1:0] keep;
    logic older_idx;

    // A write is traced only when enabled, and register zero may be filtered.
    always_comb
    begin
        for (int i = 0; i < `ISSUE_NUM; i++)
        begin
            keep[i] = rf_wen[i] && trace_enable && (!drop_zero || rf_addr[i] != '0);
        end
    end

    // Slot 1 is the older instruction, so it leads whenever it survives.
    // Otherwise the lone slot 0 write moves up into slot 1.
    assign older_idx = keep[1];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            slots.wen <= '0;
        end
        else
        begin
            slots.wen[1] <= keep[1] | keep[0];
            slots.wen[0] <= keep[1] & keep[0];
        end
    end

    always_ff @(posedge clk)
    begin
        slots.addr[1] <= rf_addr[older_idx];
        slots.data[1] <= rf_data[older_idx];
        slots.pc[1] <= rt_pc[older_idx];

        // Slot 0 only ever carries the younger write of a pair.
        slots.addr[0] <= rf_addr[0];
        slots.data[0] <= rf_data[0];
        slots.pc[0] <= rt_pc[0];
    end

endmodule

`default_nettype wire

// File: verilog/rfwrite_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module rfwrite_queue
    import retire_pkg::*;
    (
        input wire logic clk,
        input wire logic reset,
        retire_if.sink slots,
        output logic trace_valid,
        output reg_addr_t trace_addr,
        output word_t trace_data,
        output word_t trace_pc,
        output slot_count_t level,
        output logic drop_strobe,
        output logic [1:0] drop_amount
    );

    localparam int DEPTH = 1 << `QUEUE_DEPTH_LOG2;

    typedef logic [`QUEUE_DEPTH_LOG2-1:0] ptr_t;

    ptr_t head;
    ptr_t tail;
    ptr_t tail_plus1;
    slot_count_t count;
    slot_count_t free_slots;
    logic [1:0] n_req;
    logic [1:0] n_acc;
    logic first_idx;
    logic pop;

    reg_addr_t addr_mem [DEPTH];
    word_t data_mem [DEPTH];
    word_t pc_mem [DEPTH];

    assign tail_plus1 = tail + 1'b1;
    assign free_slots = slot_count_t'(DEPTH) - count;   // Pops this cycle are not counted.
    assign n_req = 2'(slots.wen[1]) + 2'(slots.wen[0]);
    assign first_idx = slots.wen[1];
    assign pop = count != '0;

    // Keep the oldest writes that fit and drop the rest.
    always_comb
    begin
        if (free_slots >= slot_count_t'(n_req))
            n_acc = n_req;
        else
            n_acc = free_slots[1:0];    // Only 0 or 1 free entries get here.
    end

    assign drop_strobe = n_acc != n_req;
    assign drop_amount = n_req - n_acc;
    assign level = count;

    always_ff @(posedge clk)
    begin
        if (n_acc != 2'd0)
        begin
            addr_mem[tail] <= slots.addr[first_idx];
            data_mem[tail] <= slots.data[first_idx];
            pc_mem[tail] <= slots.pc[first_idx];
        end
        if (n_acc == 2'd2)
        begin
            // The younger write of a pair lands right behind the older one.
            addr_mem[tail_plus1] <= slots.addr[0];
            data_mem[tail_plus1] <= slots.data[0];
            pc_mem[tail_plus1] <= slots.pc[0];
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end
        else
        begin
            tail <= tail + ptr_t'(n_acc);
            head <= head + ptr_t'(pop);
            count <= count + slot_count_t'(n_acc) - slot_count_t'(pop);
        end
    end

    // The trace outputs hold zero on every idle cycle.
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            trace_valid <= 1'b0;
            trace_addr <= '0;
            trace_data <= '0;
            trace_pc <= '0;
        end
        else if (pop)
        begin
            trace_valid <= 1'b1;
            trace_addr <= addr_mem[head];
            trace_data <= data_mem[head];
            trace_pc <= pc_mem[head];
        end
        else
        begin
            trace_valid <= 1'b0;
            trace_addr <= '0;
            trace_data <= '0;
            trace_pc <= '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/retire_trace_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module retire_trace_top
    import retire_pkg::*;
    (
        input wire logic clk,
        input wire logic reset,
        input wire logic [`ISSUE_NUM-1:0] rf_wen,
        input wire reg_addr_t [`ISSUE_NUM-1:0] rf_addr,
        input wire word_t [`ISSUE_NUM-1:0] rf_data,
        input wire word_t [`ISSUE_NUM-1:0] rt_pc,
        input wire logic cfg_we,
        input wire logic [1:0] cfg_addr,
        input wire word_t cfg_wdata,
        output word_t cfg_rdata,
        output logic trace_valid,
        output reg_addr_t trace_addr,
        output word_t trace_data,
        output word_t trace_pc
    );

    logic trace_enable;
    logic drop_zero;
    logic drop_strobe;
    logic [1:0] drop_amount;
    slot_count_t level;

    retire_if slots_if ();

    trace_config_regs cfg0
    (
        .clk          (clk),
        .reset        (reset),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .drop_strobe  (drop_strobe),
        .drop_amount  (drop_amount),
        .level        (level),
        .trace_enable (trace_enable),
        .drop_zero    (drop_zero)
    );

    retire_compactor compactor0
    (
        .clk          (clk),
        .reset        (reset),
        .rf_wen       (rf_wen),
        .rf_addr      (rf_addr),
        .rf_data      (rf_data),
        .rt_pc        (rt_pc),
        .trace_enable (trace_enable),
        .drop_zero    (drop_zero),
        .slots        (slots_if.source)
    );

    // Drops and occupancy feed back into the status registers.
    rfwrite_queue queue0
    (
        .clk         (clk),
        .reset       (reset),
        .slots       (slots_if.sink),
        .trace_valid (trace_valid),
        .trace_addr  (trace_addr),
        .trace_data  (trace_data),
        .trace_pc    (trace_pc),
        .level       (level),
        .drop_strobe (drop_strobe),
        .drop_amount (drop_amount)
    );

endmodule

`default_nettype wire

// File: test/retire_trace_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module retire_trace_assertions
    import retire_pkg::*;
    (
        input wire logic clk,
        input wire logic reset,
        input wire slot_count_t level,
        input wire logic trace_valid,
        input wire reg_addr_t trace_addr,
        input wire word_t trace_data,
        input wire word_t trace_pc
    );

    localparam int QUEUE_DEPTH = 1 << `QUEUE_DEPTH_LOG2;

    level_in_range: assert property (@(posedge clk) disable iff (reset)
        level <= slot_count_t'(QUEUE_DEPTH))
        else $error("queue level above its depth");

    // The output register comes out of reset idle.
    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !trace_valid)
        else $error("trace_valid high in the first cycle after reset");

    idle_outputs_zero: assert property (@(posedge clk) disable iff (reset)
        !trace_valid |-> (trace_addr == '0 && trace_data == '0 && trace_pc == '0))
        else $error("trace outputs not zero while trace_valid is low");

endmodule

bind rfwrite_queue retire_trace_assertions asrt0
(
    .clk         (clk),
    .reset       (reset),
    .level       (level),
    .trace_valid (trace_valid),
    .trace_addr  (trace_addr),
    .trace_data  (trace_data),
    .trace_pc    (trace_pc)
);

`default_nettype wire

// File: test/retire_trace_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "retire_config.svh"

module retire_trace_tb
    import retire_pkg::*;
    ();

    typedef struct packed
    {
        reg_addr_t addr;
        word_t data;
        word_t pc;
    } write_t;

    typedef struct packed
    {
        logic [1:0] n;
        write_t first;      // The older surviving write.
        write_t second;
    } pair_t;

    localparam int QUEUE_DEPTH = 1 << `QUEUE_DEPTH_LOG2;

    logic clk;
    logic reset;
    logic [1:0] rf_wen;
    reg_addr_t [1:0] rf_addr;
    word_t [1:0] rf_data;
    word_t [1:0] rt_pc;
    logic cfg_we;
    logic [1:0] cfg_addr;
    word_t cfg_wdata;
    word_t cfg_rdata;
    logic trace_valid;
    reg_addr_t trace_addr;
    word_t trace_data;
    word_t trace_pc;

    write_t expq[$];        // Model queue contents with the oldest write at the front.
    write_t exp_w;
    pair_t stage;           // Model of the compactor's registered slots.
    int mcount;
    int m_drops;
    logic m_enable;
    logic m_drop_zero;
    int checks;
    int errors;
    int test_start;
    int traced;
    logic hung;
    word_t rd;
    int latency;
    int traced_before;

    retire_trace_top dut0
    (
        .clk         (clk),
        .reset       (reset),
        .rf_wen      (rf_wen),
        .rf_addr     (rf_addr),
        .rf_data     (rf_data),
        .rt_pc       (rt_pc),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .trace_valid (trace_valid),
        .trace_addr  (trace_addr),
        .trace_data  (trace_data),
        .trace_pc    (trace_pc)
    );

    always #4 clk = ~clk;

    function automatic pair_t survivors(input logic [1:0] wen, input reg_addr_t [1:0] a,
                                        input word_t [1:0] d, input word_t [1:0] p,
                                        input logic en, input logic dz);
        pair_t r;
        logic keep1;
        logic keep0;
        r = '0;
        keep1 = wen[1] && en && !(dz && a[1] == '0);
        keep0 = wen[0] && en && !(dz && a[0] == '0);
        if (keep1)
        begin
            r.first = '{a[1], d[1], p[1]};
            r.second = '{a[0], d[0], p[0]};
            r.n = keep0 ? 2'd2 : 2'd1;
        end
        else if (keep0)
        begin
            r.first = '{a[0], d[0], p[0]};
            r.n = 2'd1;
        end
        return r;
    endfunction

    // Cycle model of the queue, its drops and the configuration registers.
    always @(posedge clk)
    begin : model
        int acc;
        int dropped;
        if (reset)
        begin
            mcount = 0;
            m_drops = 0;
            stage = '0;
            m_enable = 1'b1;
            m_drop_zero = 1'b0;
        end
        else
        begin
            acc = (int'(stage.n) <= QUEUE_DEPTH - mcount) ? int'(stage.n) : QUEUE_DEPTH - mcount;
            if (acc >= 1)
                expq.push_back(stage.first);
            if (acc == 2)
                expq.push_back(stage.second);
            dropped = int'(stage.n) - acc;
            if (cfg_we && cfg_addr == `CFG_ADDR_DROPS)
                m_drops = dropped;
            else
                m_drops = (m_drops + dropped > 32'hffff) ? 32'hffff : m_drops + dropped;
            mcount = mcount + acc - ((mcount != 0) ? 1 : 0);
            stage = survivors(rf_wen, rf_addr, rf_data, rt_pc, m_enable, m_drop_zero);
            if (cfg_we && cfg_addr == `CFG_ADDR_CTRL)
            begin
                m_enable = cfg_wdata[0];
                m_drop_zero = cfg_wdata[1];
            end
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset && trace_valid)
        begin
            if (expq.size() == 0)
            begin
                errors++;
                $display("Error: trace_valid arrived while no write was expected");
            end
            else
            begin
                exp_w = expq.pop_front();
                check("trace_addr", 64'(trace_addr), 64'(exp_w.addr));
                check("trace_data", 64'(trace_data), 64'(exp_w.data));
                check("trace_pc", 64'(trace_pc), 64'(exp_w.pc));
                traced++;
            end
        end
    end

    task automatic random_traffic(input int cycles, input int sparse, input int wen_min,
                                  input int addr_max);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            rf_wen = ($urandom_range(0, sparse) == 0) ? 2'($urandom_range(wen_min, 3)) : 2'b00;
            for (int s = 0; s < 2; s++)
            begin
                rf_addr[s] = reg_addr_t'($urandom_range(0, addr_max));
                rf_data[s] = $urandom();
                rt_pc[s] = $urandom();
            end
        end
        @(negedge clk);
        rf_wen = '0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            #1;             // Let the compare process take this cycle's output first.
            n++;
        end
        while ((expq.size() != 0 || mcount != 0 || stage.n != 0) && n < 400);
        if (expq.size() != 0 || mcount != 0 || stage.n != 0)
        begin
            $display("Error: timeout, the trace queue never drained");
            hung = 1'b1;
        end
    endtask

    task automatic write_cfg(input logic [1:0] addr, input word_t value);
        @(negedge clk);
        rf_wen = '0;
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = value;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic read_cfg(input logic [1:0] addr, output word_t value);
        @(negedge clk);
        cfg_addr = addr;
        #1;
        value = cfg_rdata;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial
    begin
        void'($urandom(32'h49af9bb0));
        clk = 1'b0;
        reset = 1'b1;
        rf_wen = '0;
        rf_addr = '0;
        rf_data = '0;
        rt_pc = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        checks = 0;
        errors = 0;
        test_start = 0;
        traced = 0;
        hung = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        rf_wen = 2'b01;
        rf_addr[0] = 5'd7;
        rf_data[0] = 32'hcafe0001;
        rt_pc[0] = 32'h80000010;
        latency = 0;
        do
        begin
            @(negedge clk);
            rf_wen = '0;
            latency++;
        end
        while (!trace_valid && latency < 20);
        if (!trace_valid)
        begin
            $display("Error: timeout, trace_valid never arrived for the single write");
            hung = 1'b1;
        end
        check("latency", 64'(latency), 64'd3);
        wait_drained();
        end_test("single_write");

        random_traffic(300, 3, 1, 31);
        wait_drained();
        check("traced_any", 64'(traced > 1), 64'd1);
        end_test("random_pairs");

        write_cfg(`CFG_ADDR_CTRL, 32'd0);
        traced_before = traced;
        random_traffic(60, 1, 1, 31);
        wait_drained();
        check("traced_while_disabled", 64'(traced - traced_before), 64'd0);
        write_cfg(`CFG_ADDR_CTRL, 32'd3);
        read_cfg(`CFG_ADDR_CTRL, rd);
        check("ctrl", 64'(rd), 64'd3);
        random_traffic(120, 1, 1, 3);   // Small register numbers make register zero common.
        wait_drained();
        write_cfg(`CFG_ADDR_CTRL, 32'd1);
        end_test("enable_and_filter");

        random_traffic(200, 0, 3, 31);
        read_cfg(`CFG_ADDR_LEVEL, rd);
        check("level", 64'(rd), 64'(mcount));
        wait_drained();
        read_cfg(`CFG_ADDR_DROPS, rd);
        check("drop_count", 64'(rd), 64'(m_drops));
        check("drops_seen", 64'(rd != 0), 64'd1);
        end_test("queue_full");

        write_cfg(`CFG_ADDR_DROPS, 32'd0);
        read_cfg(`CFG_ADDR_DROPS, rd);
        check("drop_count", 64'(rd), 64'd0);
        random_traffic(30, 0, 1, 31);
        wait_drained();
        read_cfg(`CFG_ADDR_LEVEL, rd);
        check("level", 64'(rd), 64'd0);
        end_test("clear_and_level");

        $display("checks %0d, writes traced %0d, errors %0d", checks, traced, errors);
        if (errors == 0 && !hung)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: retire_trace_top.f
+incdir+verilog
verilog/retire_pkg.sv
verilog/retire_if.sv
verilog/trace_config_regs.sv
verilog/retire_compactor.sv
verilog/rfwrite_queue.sv
verilog/retire_trace_top.sv
test/retire_trace_assertions.sv
test/retire_trace_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module retire_trace_tb \
    -f retire_trace_top.f -o retire_trace_sim > build.log 2>&1 &&
./obj_dir/retire_trace_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
